/* list.f */
+incdir+sim
verilog/lsu_pkg.sv
verilog/store_format.sv
verilog/lsu.sv
verilog/load_extract.sv
verilog/axi_sram.sv
verilog/lsu_top.sv
sim/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module lsu_tb \
    -Mdir "$BUILD_DIR" -o lsu_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/lsu_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* sim/lsu_tb_table.svh */
`ifndef LSU_TB_TABLE_SVH
`define LSU_TB_TABLE_SVH

// columns: op, size, unsigned, addr, wdata, expected out_data, expected out_fault.
task automatic build_table();
    // word store and load back.
    add_row(MEM_STORE, SIZE_WORD, 1'b0, 32'h0000_0100, 32'h1234_5678, 32'h0000_0000, 1'b0);
    add_row(MEM_LOAD,  SIZE_WORD, 1'b0, 32'h0000_0100, 32'h0000_0000, 32'h1234_5678, 1'b0);

    // byte stores into each lane of 0x104.
    add_row(MEM_STORE, SIZE_WORD, 1'b0, 32'h0000_0104, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(MEM_STORE, SIZE_BYTE, 1'b0, 32'h0000_0104, 32'h0000_00a1, 32'h0000_0000, 1'b0);
    add_row(MEM_STORE, SIZE_BYTE, 1'b0, 32'h0000_0105, 32'hffff_ffb2, 32'h0000_0000, 1'b0);
    add_row(MEM_STORE, SIZE_BYTE, 1'b0, 32'h0000_0106, 32'h0000_00c3, 32'h0000_0000, 1'b0);
    add_row(MEM_STORE, SIZE_BYTE, 1'b0, 32'h0000_0107, 32'h0000_00d4, 32'h0000_0000, 1'b0);
    add_row(MEM_LOAD,  SIZE_WORD, 1'b0, 32'h0000_0104, 32'h0000_0000, 32'hd4c3_b2a1, 1'b0);

    // halfword stores at offsets 0, 2 and 1 of 0x108.
    add_row(MEM_STORE, SIZE_WORD, 1'b0, 32'h0000_0108, 32'h1111_1111, 32'h0000_0000, 1'b0);
    add_row(MEM_STORE, SIZE_HALF, 1'b0, 32'h0000_0108, 32'habcd_8e7f, 32'h0000_0000, 1'b0);
    add_row(MEM_LOAD,  SIZE_WORD, 1'b0, 32'h0000_0108, 32'h0000_0000, 32'h1111_8e7f, 1'b0);
    add_row(MEM_STORE, SIZE_HALF, 1'b0, 32'h0000_010a, 32'h0000_f00d, 32'h0000_0000, 1'b0);
    add_row(MEM_LOAD,  SIZE_WORD, 1'b0, 32'h0000_0108, 32'h0000_0000, 32'hf00d_8e7f, 1'b0);
    add_row(MEM_STORE, SIZE_HALF, 1'b0, 32'h0000_0109, 32'h0000_5aa5, 32'h0000_0000, 1'b0);
    add_row(MEM_LOAD,  SIZE_WORD, 1'b0, 32'h0000_0108, 32'h0000_0000, 32'hf05a_a57f, 1'b0);

    // byte loads, signed and unsigned.
    add_row(MEM_LOAD,  SIZE_BYTE, 1'b0, 32'h0000_0104, 32'h0000_0000, 32'hffff_ffa1, 1'b0);
    add_row(MEM_LOAD,  SIZE_BYTE, 1'b1, 32'h0000_0105, 32'h0000_0000, 32'h0000_00b2, 1'b0);
    add_row(MEM_LOAD,  SIZE_BYTE, 1'b0, 32'h0000_0106, 32'h0000_0000, 32'hffff_ffc3, 1'b0);
    add_row(MEM_LOAD,  SIZE_BYTE, 1'b1, 32'h0000_0107, 32'h0000_0000, 32'h0000_00d4, 1'b0);
    add_row(MEM_LOAD,  SIZE_BYTE, 1'b0, 32'h0000_0107, 32'h0000_0000, 32'hffff_ffd4, 1'b0);
    add_row(MEM_LOAD,  SIZE_BYTE, 1'b0, 32'h0000_0101, 32'h0000_0000, 32'h0000_0056, 1'b0);
    add_row(MEM_LOAD,  SIZE_BYTE, 1'b1, 32'h0000_0103, 32'h0000_0000, 32'h0000_0012, 1'b0);

    // halfword loads.
    add_row(MEM_LOAD,  SIZE_HALF, 1'b0, 32'h0000_0108, 32'h0000_0000, 32'hffff_a57f, 1'b0);
    add_row(MEM_LOAD,  SIZE_HALF, 1'b1, 32'h0000_0108, 32'h0000_0000, 32'h0000_a57f, 1'b0);
    add_row(MEM_LOAD,  SIZE_HALF, 1'b0, 32'h0000_0109, 32'h0000_0000, 32'h0000_5aa5, 1'b0);
    add_row(MEM_LOAD,  SIZE_HALF, 1'b0, 32'h0000_010a, 32'h0000_0000, 32'hffff_f05a, 1'b0);
    add_row(MEM_LOAD,  SIZE_HALF, 1'b1, 32'h0000_010a, 32'h0000_0000, 32'h0000_f05a, 1'b0);
    add_row(MEM_LOAD,  SIZE_HALF, 1'b0, 32'h0000_0102, 32'h0000_0000, 32'h0000_1234, 1'b0);

    // no memory access, address comes back.
    add_row(MEM_NONE,  SIZE_WORD, 1'b0, 32'h0000_0abc, 32'hdead_beef, 32'h0000_0abc, 1'b0);
    add_row(MEM_NONE,  SIZE_BYTE, 1'b1, 32'h1234_5677, 32'h0000_0000, 32'h1234_5677, 1'b0);

    // ************************************************
    // error region at and above 0x400
    // ************************************************
    add_row(MEM_STORE, SIZE_WORD, 1'b0, 32'h0000_0400, 32'hcafe_f00d, 32'h0000_0000, 1'b1);
    add_row(MEM_LOAD,  SIZE_WORD, 1'b0, 32'h0000_0400, 32'h0000_0000, 32'h0000_0000, 1'b1);
    add_row(MEM_LOAD,  SIZE_BYTE, 1'b0, 32'h0000_0403, 32'h0000_0000, 32'h0000_0000, 1'b1);
    add_row(MEM_STORE, SIZE_BYTE, 1'b0, 32'h8000_0104, 32'h0000_0077, 32'h0000_0000, 1'b1);
    add_row(MEM_LOAD,  SIZE_WORD, 1'b0, 32'h0000_0104, 32'h0000_0000, 32'hd4c3_b2a1, 1'b0);

    // last word of the array.
    add_row(MEM_STORE, SIZE_WORD, 1'b0, 32'h0000_03fc, 32'h89ab_cdef, 32'h0000_0000, 1'b0);
    add_row(MEM_LOAD,  SIZE_WORD, 1'b0, 32'h0000_03fc, 32'h0000_0000, 32'h89ab_cdef, 1'b0);
    add_row(MEM_LOAD,  SIZE_HALF, 1'b1, 32'h0000_03fe, 32'h0000_0000, 32'h0000_89ab, 1'b0);
endtask

`endif

/* sim/lsu_tb.sv */
module lsu_tb
    import lsu_pkg::*;
();

    localparam int MEM_WORDS    = 256;
    localparam int READ_LATENCY = 2;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        mem_op_t           op;
        mem_size_t         size;
        logic              is_unsigned;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] exp_data;
        logic              exp_fault;
    } row_t;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    mem_op_t           in_op;
    mem_size_t         in_size;
    logic              in_unsigned;
    logic [ADDR_W-1:0] in_addr;
    logic [DATA_W-1:0] in_wdata;
    logic              out_valid;
    logic              out_ready;
    logic [DATA_W-1:0] out_data;
    logic              out_fault;

    row_t   rows[$];
    logic   table_ready = 1'b0;
    integer seed        = 32'hf6af;

    lsu_top #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) lsu_top_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_op       (in_op),
        .in_size     (in_size),
        .in_unsigned (in_unsigned),
        .in_addr     (in_addr),
        .in_wdata    (in_wdata),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_fault   (out_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ************************************************
    // table and compare helpers
    // ************************************************
    task automatic add_row(input mem_op_t op, input mem_size_t size, input logic is_unsigned,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           input logic [DATA_W-1:0] exp_data, input logic exp_fault);
        row_t row;
        row.op          = op;
        row.size        = size;
        row.is_unsigned = is_unsigned;
        row.addr        = addr;
        row.wdata       = wdata;
        row.exp_data    = exp_data;
        row.exp_fault   = exp_fault;
        rows.push_back(row);
    endtask

    `include "lsu_tb_table.svh"

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] actual,
                              input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_fault(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // ************************************************
    // watchdog
    // ************************************************
    initial begin
        longint cycles;
        wait (table_ready);
        cycles = longint'(rows.size()) * (READ_LATENCY + 12) + RESET_CYCLES;
        #(cycles * CLK_PERIOD);
        $display("timeout waiting for out_valid");
        $display("TEST FAILED");
        $fatal(1);
    end

    // ************************************************
    // stimulus loop
    // ************************************************
    initial begin
        row_t row;
        int   stall;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_op       = MEM_NONE;
        in_size     = SIZE_WORD;
        in_unsigned = 1'b0;
        in_addr     = '0;
        in_wdata    = '0;
        out_ready   = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (out_valid !== 1'b0 || out_fault !== 1'b0 || in_ready !== 1'b1) begin
            report_failure("outputs are not idle after reset");
        end
        foreach (rows[i]) begin
            row = rows[i];
            if (in_ready !== 1'b1) begin
                report_failure($sformatf("row %0d: in_ready is low before the request", i));
            end
            in_valid    = 1'b1;
            in_op       = row.op;
            in_size     = row.size;
            in_unsigned = row.is_unsigned;
            in_addr     = row.addr;
            in_wdata    = row.wdata;
            @(negedge clk);
            in_valid    = 1'b0;
            in_op       = MEM_NONE; // fields are free to change after the transfer.
            in_size     = (row.size == SIZE_BYTE) ? SIZE_HALF : SIZE_BYTE;
            in_unsigned = ~row.is_unsigned;
            in_addr     = $random(seed);
            in_wdata    = $random(seed);
            if (in_ready !== 1'b0) begin
                report_failure($sformatf("row %0d: in_ready stays high after the transfer", i));
            end
            while (out_valid !== 1'b1) @(negedge clk);
            check_data("out_data", out_data, row.exp_data);
            check_fault("out_fault", out_fault, row.exp_fault);
            stall = $unsigned($random(seed)) % 4;
            repeat (stall) begin
                @(negedge clk);
                if (out_valid !== 1'b1) begin
                    report_failure($sformatf("row %0d: out_valid dropped during a stall", i));
                end
                if (in_ready !== 1'b0) begin
                    report_failure($sformatf("row %0d: in_ready rose during a stall", i));
                end
                check_data("out_data", out_data, row.exp_data);
                check_fault("out_fault", out_fault, row.exp_fault);
            end
            out_ready = 1'b1;
            @(negedge clk);
            out_ready = 1'b0;
            if (out_valid !== 1'b0) begin
                report_failure($sformatf("row %0d: out_valid stays high after the take", i));
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

/* verilog/lsu_top.sv */
module lsu_top
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS    = 256,
    parameter int READ_LATENCY = 2
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              in_valid,
    output logic              in_ready,
    input  mem_op_t           in_op,
    input  mem_size_t         in_size,
    input  logic              in_unsigned,
    input  logic [ADDR_W-1:0] in_addr,
    input  logic [DATA_W-1:0] in_wdata,

    output logic              out_valid,
    input  logic              out_ready,
    output logic [DATA_W-1:0] out_data,
    output logic              out_fault
);

    logic [DATA_W-1:0] ld_word;
    logic [1:0]        ld_addr_lo;
    mem_size_t         ld_size;
    logic              ld_unsigned;
    logic              ld_is_load;

    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic              wready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              bvalid;
    logic              bready;
    axi_resp_t         bresp;
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic              rvalid;
    logic              rready;
    logic [DATA_W-1:0] rdata;
    axi_resp_t         rresp;

    lsu lsu_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_op       (in_op),
        .in_size     (in_size),
        .in_unsigned (in_unsigned),
        .in_addr     (in_addr),
        .in_wdata    (in_wdata),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_fault   (out_fault),
        .ld_word     (ld_word),
        .ld_addr_lo  (ld_addr_lo),
        .ld_size     (ld_size),
        .ld_unsigned (ld_unsigned),
        .ld_is_load  (ld_is_load),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp)
    );

    load_extract load_extract_inst (
        .word        (ld_word),
        .addr_lo     (ld_addr_lo),
        .size        (ld_size),
        .is_unsigned (ld_unsigned),
        .is_load     (ld_is_load),
        .data        (out_data)
    );

    axi_sram #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) axi_sram_inst (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

endmodule

/* verilog/axi_sram.sv */
module axi_sram
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS    = 256,
    parameter int READ_LATENCY = 2
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              awvalid,
    output logic              awready,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,
    output logic              bvalid,
    input  logic              bready,
    output axi_resp_t         bresp,
    input  logic              arvalid,
    output logic              arready,
    input  logic [ADDR_W-1:0] araddr,
    output logic              rvalid,
    input  logic              rready,
    output logic [DATA_W-1:0] rdata,
    output axi_resp_t         rresp
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = $clog2(READ_LATENCY + 1);

    logic [DATA_W-1:0] mem [MEM_WORDS];

    logic [ADDR_W-1:0] aw_addr_q;
    logic [ADDR_W-1:0] ar_addr_q;
    logic              aw_got;
    logic              rd_busy;
    logic [CNT_W-1:0]  lat_cnt;
    logic              wr_ok;
    logic              rd_ok;
    logic              wr_fire;
    logic              rd_fire;

    assign wr_ok   = (aw_addr_q[ADDR_W-1:2] < MEM_WORDS); // out of range gets SLVERR.
    assign rd_ok   = (ar_addr_q[ADDR_W-1:2] < MEM_WORDS);
    assign wr_fire = wvalid && wready;
    assign rd_fire = rd_busy && !rvalid && (lat_cnt == '0);

    // ************************************************
    // write channels
    // ************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
            aw_got  <= 1'b0;
        end else begin
            awready <= awvalid && !awready && !aw_got;
            wready  <= wvalid && !wready && aw_got && !bvalid;
            if (awvalid && awready) begin
                aw_got <= 1'b1;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
            end
        end
    end

    // ************************************************
    // read channels
    // ************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= RESP_OKAY;
            rd_busy <= 1'b0;
            lat_cnt <= '0;
        end else begin
            arready <= arvalid && !arready && !rd_busy;
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                lat_cnt <= CNT_W'(READ_LATENCY - 1);
            end else if (rd_fire) begin
                rvalid <= 1'b1;
                rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (rd_busy && !rvalid) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_busy <= 1'b0;
            end
        end
    end

    // ************************************************
    // storage
    // ************************************************
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            ar_addr_q <= araddr;
        end
        if (awvalid && awready) begin
            aw_addr_q <= awaddr;
        end
        if (wr_fire && wr_ok) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wstrb[i]) begin
                    mem[aw_addr_q[IDX_W+1:2]][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
        if (rd_fire) begin
            rdata <= rd_ok ? mem[ar_addr_q[IDX_W+1:2]] : '0;
        end
    end

endmodule

/* verilog/load_extract.sv */
module load_extract
    import lsu_pkg::*;
(
    input  logic [DATA_W-1:0] word,
    input  logic [1:0]        addr_lo,
    input  mem_size_t         size,
    input  logic              is_unsigned,
    input  logic              is_load,
    output logic [DATA_W-1:0] data
);

    logic [DATA_W-1:0] shifted;
    logic              byte_fill;
    logic              half_fill;

    assign shifted   = word >> {addr_lo, 3'b000}; // addressed byte lands in lane 0.
    assign byte_fill = shifted[7] && !is_unsigned;
    assign half_fill = shifted[15] && !is_unsigned;

    always_comb begin
        data = word; // non-loads pass the word as is.
        if (is_load) begin
            case (size)
                SIZE_BYTE: begin
                    data = {{(DATA_W-8){byte_fill}}, shifted[7:0]};
                end
                SIZE_HALF: begin
                    data = {{(DATA_W-16){half_fill}}, shifted[15:0]};
                end
                default: begin
                    data = shifted;
                end
            endcase
        end
    end

endmodule

/* verilog/lsu.sv */
module lsu
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              in_valid,
    output logic              in_ready,
    input  mem_op_t           in_op,
    input  mem_size_t         in_size,
    input  logic              in_unsigned,
    input  logic [ADDR_W-1:0] in_addr,
    input  logic [DATA_W-1:0] in_wdata,

    output logic              out_valid,
    input  logic              out_ready,
    output logic              out_fault,

    output logic [DATA_W-1:0] ld_word,
    output logic [1:0]        ld_addr_lo,
    output mem_size_t         ld_size,
    output logic              ld_unsigned,
    output logic              ld_is_load,

    output logic              awvalid,
    input  logic              awready,
    output logic [ADDR_W-1:0] awaddr,
    output logic              wvalid,
    input  logic              wready,
    output logic [DATA_W-1:0] wdata,
    output logic [STRB_W-1:0] wstrb,
    input  logic              bvalid,
    output logic              bready,
    input  axi_resp_t         bresp,
    output logic              arvalid,
    input  logic              arready,
    output logic [ADDR_W-1:0] araddr,
    input  logic              rvalid,
    output logic              rready,
    input  logic [DATA_W-1:0] rdata,
    input  axi_resp_t         rresp
);

    localparam logic IDLE = 1'b0;
    localparam logic BUSY = 1'b1;

    logic              state;
    mem_op_t           op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] lane_data;
    logic [STRB_W-1:0] lane_strb;
    logic              accept;
    logic              rd_done;
    logic              wr_done;
    logic              none_done;
    logic              res_fault;

    store_format store_format_inst (
        .size      (in_size),
        .addr_lo   (in_addr[1:0]),
        .data      (in_wdata),
        .lane_data (lane_data),
        .strb      (lane_strb)
    );

    assign in_ready   = (state == IDLE);
    assign accept     = in_valid && in_ready;
    assign rd_done    = rvalid && rready;
    assign wr_done    = bvalid && bready;
    assign none_done  = (state == BUSY) && (op_q != MEM_LOAD) && (op_q != MEM_STORE)
                        && !out_valid; // anything else passes its address back.
    assign res_fault  = rd_done ? (rresp != RESP_OKAY) :
                        wr_done ? (bresp != RESP_OKAY) : 1'b0;

    assign awaddr     = addr_q;
    assign araddr     = addr_q;
    assign ld_is_load = (op_q == MEM_LOAD);

    // ************************************************
    // control FSM and channel handshakes
    // ************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            op_q      <= MEM_NONE;
            out_valid <= 1'b0;
            out_fault <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            bready    <= 1'b0;
            arvalid   <= 1'b0;
            rready    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= BUSY;
                        op_q    <= in_op;
                        awvalid <= (in_op == MEM_STORE);
                        arvalid <= (in_op == MEM_LOAD);
                    end
                end
                BUSY: begin
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1; // data only after the address.
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                        bready <= 1'b1;
                    end
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (rd_done) begin
                        rready <= 1'b0;
                    end
                    if (wr_done) begin
                        bready <= 1'b0;
                    end
                    if (rd_done || wr_done || none_done) begin
                        out_valid <= 1'b1;
                        out_fault <= res_fault; // error response still completes.
                    end
                    if (out_valid && out_ready) begin
                        out_valid <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ************************************************
    // request and result payload
    // ************************************************
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q      <= {in_addr[ADDR_W-1:2], 2'b00};
            ld_addr_lo  <= in_addr[1:0];
            ld_size     <= in_size;
            ld_unsigned <= in_unsigned;
            wdata       <= lane_data;
            wstrb       <= lane_strb;
        end
        if (rd_done) begin
            ld_word <= rdata;
        end else if (wr_done) begin
            ld_word <= '0; // stores return zero.
        end else if (none_done) begin
            ld_word <= {addr_q[ADDR_W-1:2], ld_addr_lo};
        end
    end

endmodule

/* verilog/store_format.sv */
module store_format
    import lsu_pkg::*;
(
    input  mem_size_t         size,
    input  logic [1:0]        addr_lo,
    input  logic [DATA_W-1:0] data,
    output logic [DATA_W-1:0] lane_data,
    output logic [STRB_W-1:0] strb
);

    localparam logic [STRB_W-1:0] STRB_BYTE = STRB_W'(1);
    localparam logic [STRB_W-1:0] STRB_HALF = STRB_W'(3);
    localparam logic [STRB_W-1:0] STRB_WORD = {STRB_W{1'b1}};

    always_comb begin
        lane_data = data << {addr_lo, 3'b000}; // low bytes move up to lane addr_lo.
        case (size)
            SIZE_BYTE: begin
                strb = STRB_BYTE << addr_lo;
            end
            SIZE_HALF: begin
                strb = STRB_HALF << addr_lo;
            end
            SIZE_WORD: begin
                strb = STRB_WORD << addr_lo; // aligned words only.
            end
            default: begin
                strb = '0;
            end
        endcase
    end

endmodule

/* verilog/lsu_pkg.sv */
package lsu_pkg;

    // ************************************************
    // bus widths
    // ************************************************
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // ************************************************
    // operation and response codes
    // ************************************************
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

endpackage
